// File: ctn_ram.f
+incdir+source
source/ctn_pkg.sv
source/ctn_wr_port.sv
source/ctn_rd_port.sv
source/ctn_ram_arbiter.sv
source/ctn_ram.sv
verification/ctn_ram_chk.sv
verification/ctn_ram_tb.sv

// File: Makefile
# Verilator flow for the CTN RAM testbench

SHELL     := /bin/bash
VERILATOR ?= verilator
FILELIST  ?= ctn_ram.f
TOP       ?= ctn_ram_tb
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= Testbench failed
VFLAGS    ?= --timing --assert -Wall

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	set -o pipefail; ./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "simulation reported failure, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: verification/ctn_ram_tb.sv
////////////////////////////////////////////////////////////////////////////
// Testbench for the CTN RAM: directed and random AXI4-Lite traffic
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "ctn_settings.svh"

module ctn_ram_tb;
  import ctn_pkg::*;

  localparam int          NUM_RAND    = 200;
  localparam int          TIMEOUT_CYC = 20000;  // ~30 cycles per random pair, wide margin
  localparam logic [31:0] WIN_BASE    = `CTN_RAM_BASE;

  logic clk_aon, rst_n_i;
  logic awvalid_i, wvalid_i, bready_i, arvalid_i, rready_i;
  logic awready_o, wready_o, bvalid_o, arready_o, rvalid_o;
  logic [31:0] awaddr_i, araddr_i, wdata_i, rdata_o;
  logic [3:0]  wstrb_i;
  ctn_resp_e   bresp_o, rresp_o;

  logic [31:0] model [256];
  int          written_q[$];
  logic [31:0] exp_q[$], act_q[$];
  string       what_q[$];
  logic [31:0] rng = 32'h7f4e;
  bit          bp_en;
  int          err_cnt, chk_cnt, cyc;

  ctn_ram i_ctn_ram (.*);
  bind ctn_ram ctn_ram_chk i_chk (.*);

  initial begin
    clk_aon = 1'b0;
    forever #20 clk_aon = ~clk_aon;
  end

  function automatic logic [31:0] xorshift();
    rng ^= rng << 13;
    rng ^= rng >> 17;
    rng ^= rng << 5;
    return rng;
  endfunction

  // Expected word after a strobed write
  function automatic logic [31:0] merge_word(logic [31:0] old_w, logic [31:0] new_w,
                                             logic [3:0] strb);
    logic [31:0] res;
    res = old_w;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) begin
        res[b*8 +: 8] = new_w[b*8 +: 8];
      end
    end
    return res;
  endfunction

  function automatic logic [1:0] expect_resp(logic [31:0] addr);
    return (addr >= WIN_BASE && addr < WIN_BASE + `CTN_RAM_BYTES) ? OKAY : SLVERR;
  endfunction

  // True once the model holds a value for this word
  function automatic bit was_written(int idx);
    foreach (written_q[i]) begin
      if (written_q[i] == idx) return 1'b1;
    end
    return 1'b0;
  endfunction

  task automatic check(input logic [31:0] exp, input logic [31:0] act, input string what);
    chk_cnt++;
    if (exp !== act) begin
      err_cnt++;
      $display("error at %0t: %s expected %h got %h", $time, what, exp, act);
    end
  endtask

  task automatic post(input logic [31:0] exp, input logic [31:0] act, input string what);
    exp_q.push_back(exp);
    act_q.push_back(act);
    what_q.push_back(what);
  endtask

  // Comparison process
  always @(posedge clk_aon) begin
    while (act_q.size() > 0) check(exp_q.pop_front(), act_q.pop_front(), what_q.pop_front());
  end

  always @(posedge clk_aon) begin
    cyc++;
    if (cyc >= TIMEOUT_CYC) begin
      $display("timeout: run still busy after %0d cycles", cyc);
      $display("Testbench failed");
      $finish;
    end
  end

  function automatic logic host_ready();
    logic [31:0] rnd;
    if (!bp_en) return 1'b1;
    rnd = xorshift();
    return rnd[3];
  endfunction

  task automatic write_and_model(input logic [31:0] addr, input logic [31:0] data,
                                 input logic [3:0] strb);
    int idx;
    @(negedge clk_aon);
    awvalid_i = 1'b1;
    wvalid_i  = 1'b1;
    awaddr_i  = addr;
    wdata_i   = data;
    wstrb_i   = strb;
    #1;
    while (!awready_o) @(negedge clk_aon) #1;
    post(1'b1, wready_o, "wready with awready");
    @(negedge clk_aon);
    awvalid_i = 1'b0;
    wvalid_i  = 1'b0;
    bready_i  = host_ready();
    while (!(bvalid_o && bready_i)) @(negedge clk_aon) bready_i = host_ready();
    post(expect_resp(addr), bresp_o, "write response");
    if (expect_resp(addr) == OKAY) begin
      idx = (addr - WIN_BASE) >> 2;
      if (!was_written(idx)) begin
        written_q.push_back(idx);
      end
      model[idx] = merge_word(model[idx], data, strb);
    end
    @(negedge clk_aon);
    bready_i = 1'b0;
  endtask

  task automatic read_and_check(input logic [31:0] addr);
    logic [31:0] exp_data;
    @(negedge clk_aon);
    arvalid_i = 1'b1;
    araddr_i  = addr;
    #1;
    while (!arready_o) @(negedge clk_aon) #1;
    @(negedge clk_aon);
    arvalid_i = 1'b0;
    rready_i  = host_ready();
    while (!(rvalid_o && rready_i)) @(negedge clk_aon) rready_i = host_ready();
    exp_data = (expect_resp(addr) == OKAY) ? model[(addr - WIN_BASE) >> 2] : 32'h0;
    post(expect_resp(addr), rresp_o, "read response");
    post(exp_data, rdata_o, "read data");
    @(negedge clk_aon);
    rready_i = 1'b0;
  endtask

  initial begin
    int          widx, ridx;
    logic [31:0] waddr, raddr;
    logic [31:0] wdata, rnd;
    logic [3:0]  wstrb;
    rst_n_i   = 1'b0;
    awvalid_i = 1'b0;
    wvalid_i  = 1'b0;
    bready_i  = 1'b0;
    arvalid_i = 1'b0;
    rready_i  = 1'b0;
    awaddr_i  = '0;
    araddr_i  = '0;
    wdata_i   = '0;
    wstrb_i   = '0;
    repeat (2) @(posedge clk_aon);
    @(negedge clk_aon) rst_n_i = 1'b1;
    #1 post(5'b0, {awready_o, wready_o, arready_o, bvalid_o, rvalid_o}, "idle outputs");

    // Full-word write and read back
    for (int i = 0; i < 8; i++) begin
      write_and_model(WIN_BASE + i * 17 * 4, xorshift(), 4'hf);
      read_and_check(WIN_BASE + i * 17 * 4);
    end
    // Partial strobes
    write_and_model(WIN_BASE, xorshift(), 4'b0101);
    read_and_check(WIN_BASE);
    write_and_model(WIN_BASE + 17 * 4, xorshift(), 4'b1000);
    read_and_check(WIN_BASE + 17 * 4);
    // Outside the window, same word index as a written word
    write_and_model(32'h0002_0000 + 17 * 4, 32'hdead_beef, 4'hf);
    read_and_check(WIN_BASE + 17 * 4);
    read_and_check(32'h0003_0044);

    ////////////////////////////////////////////////////////////////////////////
    // Random concurrent traffic with back-pressure
    ////////////////////////////////////////////////////////////////////////////
    bp_en = 1'b1;
    repeat (NUM_RAND) begin
      widx  = xorshift() % 256;
      waddr = (xorshift() % 8 == 0) ? 32'h0004_0000 + widx * 4 : WIN_BASE + widx * 4;
      ridx  = written_q[xorshift() % written_q.size()];
      raddr = (ridx == widx) ? 32'h0005_0000 + ridx * 4 : WIN_BASE + ridx * 4;
      wdata = xorshift();
      rnd   = xorshift();
      // A word's first write fills it completely
      wstrb = was_written(widx) ? (rnd[3:0] | 4'b0001) : 4'hf;
      fork
        write_and_model(waddr, wdata, wstrb);
        read_and_check(raddr);
      join
    end
    bp_en = 1'b0;

    repeat (4) @(posedge clk_aon);
    $display("checks: %0d, errors: %0d", chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

// File: verification/ctn_ram_chk.sv
////////////////////////////////////////////////////////////////////////////
// Handshake assertions for the CTN RAM AXI4-Lite slave, bound to the top
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module ctn_ram_chk (
  input logic        clk_aon,
  input logic        rst_n_i,
  input logic        awready_o,
  input logic        wready_o,
  input logic        arready_o,
  input logic        wvalid_i,
  input logic        bvalid_o,
  input logic        bready_i,
  input logic [1:0]  bresp_o,
  input logic        rvalid_o,
  input logic        rready_i,
  input logic [31:0] rdata_o
);

  // Responses stay up and steady until the host takes them
  a_b_hold: assert property (@(posedge clk_aon) disable iff (!rst_n_i)
    bvalid_o && !bready_i |=> bvalid_o && $stable(bresp_o))
    else $error("write response dropped or changed while stalled");

  a_r_hold: assert property (@(posedge clk_aon) disable iff (!rst_n_i)
    rvalid_o && !rready_i |=> rvalid_o && $stable(rdata_o))
    else $error("read response dropped or changed while stalled");

  a_aw_join: assert property (@(posedge clk_aon) disable iff (!rst_n_i)
    awready_o |-> wvalid_i)
    else $error("awready raised without wvalid");

  a_reset: assert property (@(posedge clk_aon)
    !rst_n_i |-> !bvalid_o && !rvalid_o && !awready_o && !wready_o && !arready_o)
    else $error("handshake output high during reset");

endmodule

// File: source/ctn_ram.sv
////////////////////////////////////////////////////////////////////////////
// CTN RAM top level: AXI4-Lite slave over a shared single-port RAM
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "ctn_settings.svh"

module ctn_ram (
  input  logic                     clk_aon,
  input  logic                     rst_n_i,

  // Write address, data and response
  input  logic                     awvalid_i,
  output logic                     awready_o,
  input  logic [31:0]              awaddr_i,
  input  logic                     wvalid_i,
  output logic                     wready_o,
  input  logic [`CTN_DATA_W-1:0]   wdata_i,
  input  logic [`CTN_DATA_W/8-1:0] wstrb_i,
  output logic                     bvalid_o,
  input  logic                     bready_i,
  output ctn_pkg::ctn_resp_e       bresp_o,

  // Read address and data
  input  logic                     arvalid_i,
  output logic                     arready_o,
  input  logic [31:0]              araddr_i,
  output logic                     rvalid_o,
  input  logic                     rready_i,
  output logic [`CTN_DATA_W-1:0]   rdata_o,
  output ctn_pkg::ctn_resp_e       rresp_o
);

  // Write unit to arbiter
  logic                     wr_req;
  logic                     wr_gnt;
  logic [`CTN_IDX_W-1:0]    wr_idx;
  logic [`CTN_DATA_W-1:0]   wr_data;
  logic [`CTN_DATA_W/8-1:0] wr_strb;

  // Read unit to arbiter
  logic                     rd_req;
  logic                     rd_gnt;
  logic [`CTN_IDX_W-1:0]    rd_idx;
  logic [`CTN_DATA_W-1:0]   rd_data;
  logic                     rd_data_vld;

  ctn_wr_port i_wr_port (
    .clk_aon   (clk_aon),
    .rst_n_i   (rst_n_i),
    .awvalid_i (awvalid_i),
    .awaddr_i  (awaddr_i),
    .wvalid_i  (wvalid_i),
    .wdata_i   (wdata_i),
    .wstrb_i   (wstrb_i),
    .bready_i  (bready_i),
    .wr_gnt_i  (wr_gnt),
    .awready_o (awready_o),
    .wready_o  (wready_o),
    .bvalid_o  (bvalid_o),
    .bresp_o   (bresp_o),
    .wr_req_o  (wr_req),
    .wr_idx_o  (wr_idx),
    .wr_data_o (wr_data),
    .wr_strb_o (wr_strb)
  );

  ctn_rd_port i_rd_port (
    .clk_aon       (clk_aon),
    .rst_n_i       (rst_n_i),
    .arvalid_i     (arvalid_i),
    .araddr_i      (araddr_i),
    .rready_i      (rready_i),
    .rd_gnt_i      (rd_gnt),
    .rd_data_i     (rd_data),
    .rd_data_vld_i (rd_data_vld),
    .arready_o     (arready_o),
    .rvalid_o      (rvalid_o),
    .rdata_o       (rdata_o),
    .rresp_o       (rresp_o),
    .rd_req_o      (rd_req),
    .rd_idx_o      (rd_idx)
  );

  // Owns the RAM, one access per cycle
  ctn_ram_arbiter i_ram_arbiter (
    .clk_aon       (clk_aon),
    .rst_n_i       (rst_n_i),
    .wr_req_i      (wr_req),
    .wr_idx_i      (wr_idx),
    .wr_data_i     (wr_data),
    .wr_strb_i     (wr_strb),
    .rd_req_i      (rd_req),
    .rd_idx_i      (rd_idx),
    .wr_gnt_o      (wr_gnt),
    .rd_gnt_o      (rd_gnt),
    .rd_data_o     (rd_data),
    .rd_data_vld_o (rd_data_vld)
  );

endmodule

// File: source/ctn_ram_arbiter.sv
////////////////////////////////////////////////////////////////////////////
// Single-port RAM storage with alternating-priority read/write arbiter
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "ctn_settings.svh"

module ctn_ram_arbiter (
  input  logic                     clk_aon,
  input  logic                     rst_n_i,
  input  logic                     wr_req_i,
  input  logic [`CTN_IDX_W-1:0]    wr_idx_i,
  input  logic [`CTN_DATA_W-1:0]   wr_data_i,
  input  logic [`CTN_DATA_W/8-1:0] wr_strb_i,
  input  logic                     rd_req_i,
  input  logic [`CTN_IDX_W-1:0]    rd_idx_i,
  output logic                     wr_gnt_o,
  output logic                     rd_gnt_o,
  output logic [`CTN_DATA_W-1:0]   rd_data_o,
  output logic                     rd_data_vld_o
);

  localparam int NUM_BYTES = `CTN_DATA_W / 8;

  logic [`CTN_DATA_W-1:0] mem [`CTN_RAM_WORDS];
  logic                   last_rd_q;  // Channel served by the previous grant

  ////////////////////////////////////////////////////////////////////////////
  // Arbitration
  ////////////////////////////////////////////////////////////////////////////

  // A lone request always wins, a tie goes to the channel served less recently
  assign wr_gnt_o = wr_req_i && (!rd_req_i || last_rd_q);
  assign rd_gnt_o = rd_req_i && (!wr_req_i || !last_rd_q);

  always_ff @(posedge clk_aon or negedge rst_n_i) begin
    if (!rst_n_i) begin
      last_rd_q     <= 1'b1;
      rd_data_vld_o <= 1'b0;
    end else begin
      rd_data_vld_o <= rd_gnt_o;
      if (wr_gnt_o) begin
        last_rd_q <= 1'b0;
      end else if (rd_gnt_o) begin
        last_rd_q <= 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Storage
  ////////////////////////////////////////////////////////////////////////////

  // Byte lanes with a clear strobe keep their old contents
  always_ff @(posedge clk_aon) begin
    if (wr_gnt_o) begin
      for (int b = 0; b < NUM_BYTES; b++) begin
        if (wr_strb_i[b]) begin
          mem[wr_idx_i][b*8 +: 8] <= wr_data_i[b*8 +: 8];
        end
      end
    end
  end

  // Registered read port, word valid one cycle after the grant
  always_ff @(posedge clk_aon) begin
    if (rd_gnt_o) begin
      rd_data_o <= mem[rd_idx_i];
    end
  end

endmodule

// File: source/ctn_rd_port.sv
////////////////////////////////////////////////////////////////////////////
// AXI4-Lite read channel unit: window check, RAM request, R response
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "ctn_settings.svh"

module ctn_rd_port (
  input  logic                   clk_aon,
  input  logic                   rst_n_i,
  input  logic                   arvalid_i,
  input  logic [31:0]            araddr_i,
  input  logic                   rready_i,
  input  logic                   rd_gnt_i,
  input  logic [`CTN_DATA_W-1:0] rd_data_i,
  input  logic                   rd_data_vld_i,
  output logic                   arready_o,
  output logic                   rvalid_o,
  output logic [`CTN_DATA_W-1:0] rdata_o,
  output ctn_pkg::ctn_resp_e     rresp_o,
  output logic                   rd_req_o,
  output logic [`CTN_IDX_W-1:0]  rd_idx_o
);
  import ctn_pkg::*;

  localparam logic [1:0] ST_IDLE = 2'd0;
  localparam logic [1:0] ST_REQ  = 2'd1;
  localparam logic [1:0] ST_DATA = 2'd2;  // Granted, word due next cycle
  localparam logic [1:0] ST_RESP = 2'd3;

  logic [1:0]            state_q;
  logic                  in_win;
  ctn_addr_u             ar_addr;
  logic [`CTN_IDX_W-1:0] idx_q;

  assign ar_addr.raw = araddr_i;
  assign in_win      = ctn_in_window(ar_addr);

  assign arready_o = (state_q == ST_IDLE) && arvalid_i;
  assign rd_req_o  = (state_q == ST_REQ);
  assign rd_idx_o  = idx_q;
  assign rvalid_o  = (state_q == ST_RESP);

  always_ff @(posedge clk_aon or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= ST_IDLE;
    end else begin
      case (state_q)
        ST_IDLE: if (arready_o) state_q <= in_win ? ST_REQ : ST_RESP;
        ST_REQ:  if (rd_gnt_i) state_q <= ST_DATA;
        ST_DATA: if (rd_data_vld_i) state_q <= ST_RESP;
        default: if (rready_i) state_q <= ST_IDLE;  // ST_RESP
      endcase
    end
  end

  // Response payload, held while the host stalls
  always_ff @(posedge clk_aon) begin
    if (arready_o) begin
      idx_q   <= ar_addr.f.word_idx;
      rdata_o <= '0;                       // Stays zero for SLVERR
      rresp_o <= in_win ? OKAY : SLVERR;
    end else if ((state_q == ST_DATA) && rd_data_vld_i) begin
      rdata_o <= rd_data_i;
    end
  end

endmodule

// File: source/ctn_wr_port.sv
////////////////////////////////////////////////////////////////////////////
// AXI4-Lite write channel unit: AW/W join, window check, B response
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "ctn_settings.svh"

module ctn_wr_port (
  input  logic                     clk_aon,
  input  logic                     rst_n_i,
  input  logic                     awvalid_i,
  input  logic [31:0]              awaddr_i,
  input  logic                     wvalid_i,
  input  logic [`CTN_DATA_W-1:0]   wdata_i,
  input  logic [`CTN_DATA_W/8-1:0] wstrb_i,
  input  logic                     bready_i,
  input  logic                     wr_gnt_i,
  output logic                     awready_o,
  output logic                     wready_o,
  output logic                     bvalid_o,
  output ctn_pkg::ctn_resp_e       bresp_o,
  output logic                     wr_req_o,
  output logic [`CTN_IDX_W-1:0]    wr_idx_o,
  output logic [`CTN_DATA_W-1:0]   wr_data_o,
  output logic [`CTN_DATA_W/8-1:0] wr_strb_o
);
  import ctn_pkg::*;

  localparam logic [1:0] ST_IDLE = 2'd0;
  localparam logic [1:0] ST_WAIT = 2'd1;  // Granted next cycle at the latest
  localparam logic [1:0] ST_RESP = 2'd2;

  logic [1:0]               state_q;
  logic                     accept;
  logic                     in_win;
  ctn_addr_u                aw_addr;
  logic [`CTN_IDX_W-1:0]    idx_q;
  logic [`CTN_DATA_W-1:0]   data_q;
  logic [`CTN_DATA_W/8-1:0] strb_q;
  ctn_resp_e                bresp_q;

  assign aw_addr.raw = awaddr_i;
  assign in_win      = ctn_in_window(aw_addr);

  // AW and W are taken together, never one without the other
  assign accept    = (state_q == ST_IDLE) && awvalid_i && wvalid_i;
  assign awready_o = accept;
  assign wready_o  = accept;

  // Acceptance cycle drives the bus fields, the hold registers cover a lost arbitration
  assign wr_req_o  = (accept && in_win) || (state_q == ST_WAIT);
  assign wr_idx_o  = (state_q == ST_WAIT) ? idx_q  : aw_addr.f.word_idx;
  assign wr_data_o = (state_q == ST_WAIT) ? data_q : wdata_i;
  assign wr_strb_o = (state_q == ST_WAIT) ? strb_q : wstrb_i;

  assign bvalid_o = (state_q == ST_RESP);
  assign bresp_o  = bresp_q;

  always_ff @(posedge clk_aon or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= ST_IDLE;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (accept) begin
            // Out-of-window writes skip the RAM entirely
            state_q <= (!in_win || wr_gnt_i) ? ST_RESP : ST_WAIT;
          end
        end
        ST_WAIT: if (wr_gnt_i) state_q <= ST_RESP;
        ST_RESP: if (bready_i) state_q <= ST_IDLE;
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_aon) begin
    if (accept) begin
      idx_q   <= aw_addr.f.word_idx;
      data_q  <= wdata_i;
      strb_q  <= wstrb_i;
      bresp_q <= in_win ? OKAY : SLVERR;
    end
  end

endmodule

// File: source/ctn_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Address word union, AXI response codes and the window check
////////////////////////////////////////////////////////////////////////////

`include "ctn_settings.svh"

package ctn_pkg;

  // Bits above the window offset select the window
  localparam int CTN_TAG_W = 32 - $clog2(`CTN_RAM_BYTES);

  typedef struct packed {
    logic [CTN_TAG_W-1:0]  win_tag;
    logic [`CTN_IDX_W-1:0] word_idx;
    logic [1:0]            byte_off;  // Ignored, accesses are word wide
  } ctn_addr_s;

  // One bus address, seen raw or split into fields
  typedef union packed {
    logic [31:0] raw;
    ctn_addr_s   f;
  } ctn_addr_u;

  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    SLVERR = 2'b10
  } ctn_resp_e;

  function automatic logic ctn_in_window(ctn_addr_u addr);
    ctn_addr_u base;
    base.raw = `CTN_RAM_BASE;
    return addr.f.win_tag == base.f.win_tag;
  endfunction

endpackage

// File: source/ctn_settings.svh
////////////////////////////////////////////////////////////////////////////
// Window placement, bus data width and RAM geometry for the CTN RAM
////////////////////////////////////////////////////////////////////////////

`ifndef CTN_SETTINGS_SVH
`define CTN_SETTINGS_SVH

// Bus data width in bits
`define CTN_DATA_W 32

// RAM depth in words and the matching word-index width
`define CTN_RAM_WORDS 256
`define CTN_IDX_W 8

// Address window, base aligned to its own size
`define CTN_RAM_BASE 32'h0001_0000
`define CTN_RAM_BYTES 1024

`endif
